/* Makefile */
# Verilator build and run of the CSR stage testbench

VERILATOR ?= verilator
TOP       ?= csr_stage_tb
FILELIST  ?= csr_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

PASS_TEXT := No errors
SOURCES   := $(wildcard source/*.sv) $(wildcard include/*.svh) $(wildcard tb/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the run prints the pass line
test: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* csr_stage.f */
+incdir+include
source/csr_pkg.sv
source/csr_if.sv
source/csr_access.sv
source/csr_file.sv
source/trap_unit.sv
source/csr_stage.sv
tb/csr_stage_tb.sv

/* include/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath widths
`define XLEN                32
`define CSR_ADDR_W          12
`define COUNTER_W           64

// Machine trap setup
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305

// Machine trap handling
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// Machine information, all read as zero
`define CSR_ADDR_MVENDORID  12'hf11
`define CSR_ADDR_MARCHID    12'hf12
`define CSR_ADDR_MIMPID     12'hf13
`define CSR_ADDR_MHARTID    12'hf14

// User counter views, readable from U mode
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_CYCLEH     12'hc80
`define CSR_ADDR_TIME       12'hc01
`define CSR_ADDR_TIMEH      12'hc81

// Machine counter views
`define CSR_ADDR_MCYCLE     12'hb00
`define CSR_ADDR_MCYCLEH    12'hb80

// MXL = 32 bit, extensions A, I and M
`define MISA_VALUE          32'h4000_1101

// Cause codes, bit 31 marks an interrupt
`define CAUSE_ECALL_U       32'd8
`define CAUSE_ECALL_M       32'd11
`define CAUSE_MTIMER_INT    32'h8000_0007

`endif

/* source/csr_access.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_access (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  csr_pkg::csr_cmd_e    csr_cmd_in,
    input  logic [`XLEN-1:0]     op1_data,
    input  logic [`XLEN-1:0]     imm_i,
    input  csr_pkg::priv_mode_e  mode,
    csr_req_if.access            req
);
    import csr_pkg::*;

    csr_cmd_e                cmd;
    logic [`CSR_ADDR_W-1:0]  addr;
    logic                    priv_ok;
    logic                    addr_known;
    logic                    wr_allowed;
    logic                    is_rmw;

    // Flush kills the command, unused codes fold into CSR_X
    always_comb begin
        case (csr_cmd_in)
            CSR_W, CSR_S, CSR_C, CSR_ECALL, CSR_MRET: cmd = flush ? CSR_X : csr_cmd_in;
            default: cmd = CSR_X;
        endcase
    end

    // All ones never decodes, so a flushed read returns zero
    assign addr = flush ? '1 : imm_i[`CSR_ADDR_W-1:0];

    // Implemented addresses
    always_comb begin
        case (addr)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
            `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MIP,
            `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID,
            `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH, `CSR_ADDR_TIME, `CSR_ADDR_TIMEH,
            `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH: addr_known = 1'b1;
            default: addr_known = 1'b0;
        endcase
    end

    // Bits 9:8 give the lowest mode allowed
    assign priv_ok    = addr[9:8] <= mode;
    // Bits 11:10 both set means read only
    assign wr_allowed = priv_ok && (addr[11:10] != 2'b11);
    assign is_rmw     = cmd inside {CSR_W, CSR_S, CSR_C};

    assign req.cmd     = cmd;
    assign req.rd_addr = addr;
    assign req.rd_ok   = priv_ok && addr_known;

    // Write stage control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.wr_cmd <= CSR_X;
            req.wr_ok  <= 1'b0;
        end else begin
            req.wr_cmd <= cmd;
            req.wr_ok  <= is_rmw && wr_allowed;
        end
    end

    // Write stage payload
    always_ff @(posedge clk) begin
        req.wr_addr <= addr;
        req.wr_op1  <= op1_data;
    end

    // A trap or idle slot must never reach the write port
    a_wr_ok_rmw: assert property (@(posedge clk) disable iff (!rst_n)
        req.wr_ok |-> (req.wr_cmd inside {CSR_W, CSR_S, CSR_C}))
        else $error("wr_ok with non write command %0d", req.wr_cmd);

endmodule

/* source/csr_file.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`COUNTER_W-1:0]   cycle,
    input  logic [`COUNTER_W-1:0]   time_cnt,
    input  logic [`COUNTER_W-1:0]   mtime,
    input  logic [`COUNTER_W-1:0]   mtimecmp,
    output logic [`XLEN-1:0]        csr_rdata,
    csr_req_if.file                 req,
    trap_if.file                    trap
);
    import csr_pkg::*;

    // MIE, MPIE, MPP and MPRV
    localparam logic [`XLEN-1:0] MSTATUS_WMASK = 32'h0002_1888;
    // MSIE, MTIE and MEIE
    localparam logic [`XLEN-1:0] MIE_WMASK     = 32'h0000_0888;

    mstatus_u          mstatus_q;
    mstatus_u          mstatus_wr;
    logic [`XLEN-1:0]  mie_q;
    logic [`XLEN-1:0]  mtvec_q;
    logic [`XLEN-1:0]  mscratch_q;
    logic [`XLEN-1:0]  mepc_q;
    logic [`XLEN-1:0]  mcause_q;
    logic [`XLEN-1:0]  rd_val;
    logic [`XLEN-1:0]  wr_val;
    logic              timer_pending;
    logic              entry_trap;
    logic              status_trap;

    assign timer_pending = mtime >= mtimecmp;

    // Trap entry owns mcause, mepc and mstatus, mret owns mstatus
    assign entry_trap  = trap.take_int || trap.do_ecall;
    assign status_trap = entry_trap || trap.do_mret;

    // Read multiplexer
    always_comb begin
        case (req.rd_addr)
            `CSR_ADDR_MSTATUS:  rd_val = mstatus_q.raw;
            `CSR_ADDR_MISA:     rd_val = `MISA_VALUE;
            `CSR_ADDR_MIE:      rd_val = mie_q;
            `CSR_ADDR_MTVEC:    rd_val = mtvec_q;
            `CSR_ADDR_MSCRATCH: rd_val = mscratch_q;
            `CSR_ADDR_MEPC:     rd_val = mepc_q;
            `CSR_ADDR_MCAUSE:   rd_val = mcause_q;
            // Timer pending is live, not stored
            `CSR_ADDR_MIP:      rd_val = {{(`XLEN-8){1'b0}}, timer_pending, 7'b0};
            `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID,
            `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID: rd_val = '0;
            `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:   rd_val = cycle[`XLEN-1:0];
            `CSR_ADDR_CYCLEH, `CSR_ADDR_MCYCLEH: rd_val = cycle[`COUNTER_W-1:`XLEN];
            `CSR_ADDR_TIME:     rd_val = time_cnt[`XLEN-1:0];
            `CSR_ADDR_TIMEH:    rd_val = time_cnt[`COUNTER_W-1:`XLEN];
            default:            rd_val = '0;
        endcase
    end

    // Old value for the instruction, also the base of set and clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_rdata <= '0;
        end else begin
            csr_rdata <= req.rd_ok ? rd_val : '0;
        end
    end

    // New value, one cycle after the read
    always_comb begin
        case (req.wr_cmd)
            CSR_W:   wr_val = req.wr_op1;
            CSR_S:   wr_val = csr_rdata | req.wr_op1;
            CSR_C:   wr_val = csr_rdata & ~req.wr_op1;
            default: wr_val = '0;
        endcase
    end

    // MPP only holds U or M
    always_comb begin
        mstatus_wr.raw = wr_val & MSTATUS_WMASK;
        if (mstatus_wr.fields.mpp != MODE_M) begin
            mstatus_wr.fields.mpp = MODE_U;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q.raw        <= '0;
            mstatus_q.fields.mpp <= MODE_M;
            mie_q                <= '0;
            mtvec_q              <= '0;
            mscratch_q           <= '0;
            mepc_q               <= '0;
            mcause_q             <= '0;
        end else begin
            // Counters, misa, mip and identity ignore writes
            if (req.wr_ok) begin
                case (req.wr_addr)
                    `CSR_ADDR_MSTATUS:  if (!status_trap) mstatus_q <= mstatus_wr;
                    `CSR_ADDR_MIE:      mie_q <= wr_val & MIE_WMASK;
                    `CSR_ADDR_MTVEC:    mtvec_q <= wr_val;
                    `CSR_ADDR_MSCRATCH: mscratch_q <= wr_val;
                    `CSR_ADDR_MEPC:     if (!entry_trap) mepc_q <= {wr_val[`XLEN-1:2], 2'b00};
                    `CSR_ADDR_MCAUSE:   if (!entry_trap) mcause_q <= wr_val;
                    default: begin
                    end
                endcase
            end
            // Trap entry from either mode
            if (entry_trap) begin
                mcause_q              <= trap.cause;
                mepc_q                <= trap.epc;
                mstatus_q.fields.mpie <= mstatus_q.fields.mie;
                mstatus_q.fields.mie  <= 1'b0;
                mstatus_q.fields.mpp  <= trap.mode;
            end else if (trap.do_mret) begin
                mstatus_q.fields.mie <= mstatus_q.fields.mpie;
                mstatus_q.fields.mpp <= MODE_U;
                // Leaving M drops the modified privilege
                if (mstatus_q.fields.mpp != MODE_M) begin
                    mstatus_q.fields.mprv <= 1'b0;
                end
            end
        end
    end

    assign trap.mstatus = mstatus_q;
    assign trap.mtvec   = mtvec_q;
    assign trap.mepc    = mepc_q;
    assign trap.mtie    = mie_q[7];
    assign trap.mtip    = timer_pending;

    // An interrupt overrides the command, so mret cannot come with it
    a_int_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap.take_int && trap.do_mret))
        else $error("take_int and do_mret in the same cycle");

endmodule

/* source/csr_if.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

// Request from the access decoder to the register file and trap logic
interface csr_req_if;
    import csr_pkg::*;

    // Current cycle, already squashed by flush
    csr_cmd_e                cmd;
    logic [`CSR_ADDR_W-1:0]  rd_addr;
    logic                    rd_ok;

    // Write stage, one cycle behind
    csr_cmd_e                wr_cmd;
    logic [`CSR_ADDR_W-1:0]  wr_addr;
    logic [`XLEN-1:0]        wr_op1;
    logic                    wr_ok;

    modport access (output cmd, rd_addr, rd_ok, wr_cmd, wr_addr, wr_op1, wr_ok);
    modport file   (input  rd_addr, rd_ok, wr_cmd, wr_addr, wr_op1, wr_ok);
    modport trap   (input  cmd);
endinterface

// Trap decisions one way, machine state the other way
interface trap_if;
    import csr_pkg::*;

    // From trap_unit
    logic              take_int;
    logic              do_ecall;
    logic              do_mret;
    logic [`XLEN-1:0]  cause;
    logic [`XLEN-1:0]  epc;
    priv_mode_e        mode;

    // From csr_file
    mstatus_u          mstatus;
    logic [`XLEN-1:0]  mtvec;
    logic [`XLEN-1:0]  mepc;
    logic              mtie;
    logic              mtip;

    modport trap (output take_int, do_ecall, do_mret, cause, epc, mode,
                  input  mstatus, mtvec, mepc, mtie, mtip);
    modport file (input  take_int, do_ecall, do_mret, cause, epc, mode,
                  output mstatus, mtvec, mepc, mtie, mtip);
endinterface

/* source/csr_pkg.sv */
`include "csr_settings.svh"

package csr_pkg;

    // Command strobes from the decode stage
    // Codes 6 and 7 are unused and behave as CSR_X
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only user and machine mode exist
    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } priv_mode_e;

    // mstatus with the four implemented fields
    // Everything else reads as zero
    typedef struct packed {
        logic [13:0] rsvd_31_18;
        // Bit 17
        logic        mprv;
        logic [3:0]  rsvd_16_13;
        // Bits 12:11
        priv_mode_e  mpp;
        logic [2:0]  rsvd_10_8;
        // Bit 7
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        // Bit 3
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    // Raw word for CSR reads and writes, fields for trap handling
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_fields_t  fields;
    } mstatus_u;

endpackage

/* source/csr_stage.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`COUNTER_W-1:0]  cycle,
    input  logic [`COUNTER_W-1:0]  time_cnt,
    input  logic [`COUNTER_W-1:0]  mtime,
    input  logic [`COUNTER_W-1:0]  mtimecmp,
    input  logic                   flush,
    input  csr_pkg::csr_cmd_e      csr_cmd_in,
    input  logic [`XLEN-1:0]       op1_data,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic                   interrupt_ready,
    input  logic [`XLEN-1:0]       fetch_pc,
    output csr_pkg::csr_cmd_e      out_csr_cmd,
    output logic [`XLEN-1:0]       csr_rdata,
    output logic [`XLEN-1:0]       trap_vector,
    output logic                   stall_may_interrupt
);
    import csr_pkg::*;

    // Current mode back into the access check
    priv_mode_e  mode;

    csr_req_if req_bus ();
    trap_if    trap_bus ();

    // Decode and privilege check
    csr_access csr_access_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .csr_cmd_in (csr_cmd_in),
        .op1_data   (op1_data),
        .imm_i      (imm_i),
        .mode       (mode),
        .req        (req_bus.access)
    );

    // Register state
    csr_file csr_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cycle     (cycle),
        .time_cnt  (time_cnt),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .csr_rdata (csr_rdata),
        .req       (req_bus.file),
        .trap      (trap_bus.file)
    );

    // Mode, interrupts and jump targets
    trap_unit trap_unit_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .out_csr_cmd         (out_csr_cmd),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt),
        .mode                (mode),
        .req                 (req_bus.trap),
        .trap                (trap_bus.trap)
    );

endmodule

/* source/trap_unit.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

module trap_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 interrupt_ready,
    input  logic [`XLEN-1:0]     fetch_pc,
    output csr_pkg::csr_cmd_e    out_csr_cmd,
    output logic [`XLEN-1:0]     trap_vector,
    output logic                 stall_may_interrupt,
    output csr_pkg::priv_mode_e  mode,
    csr_req_if.trap              req,
    trap_if.trap                 trap
);
    import csr_pkg::*;

    priv_mode_e        mode_q;
    logic              int_pending;
    logic              take_int;
    logic [`XLEN-1:0]  cause;
    logic [`XLEN-1:0]  mtvec_base;
    logic [`XLEN-1:0]  int_vector;

    // Timer interrupt enabled for the current mode
    // U mode ignores MIE, M mode needs it
    assign int_pending = trap.mtip && trap.mtie &&
                         ((mode_q == MODE_M && trap.mstatus.fields.mie) ||
                          mode_q == MODE_U);

    // Upstream holds off while a trap is possible
    assign stall_may_interrupt = int_pending;
    assign take_int            = int_pending && interrupt_ready;

    // Interrupt wins over the command of this cycle
    assign trap.take_int = take_int;
    assign trap.do_ecall = !take_int && (req.cmd == CSR_ECALL);
    assign trap.do_mret  = !take_int && (req.cmd == CSR_MRET);

    always_comb begin
        if (take_int) begin
            cause = `CAUSE_MTIMER_INT;
        end else if (mode_q == MODE_U) begin
            cause = `CAUSE_ECALL_U;
        end else begin
            cause = `CAUSE_ECALL_M;
        end
    end

    assign trap.cause = cause;
    assign trap.epc   = fetch_pc;
    assign trap.mode  = mode_q;
    assign mode       = mode_q;

    // mtvec mode 1 is vectored, anything else direct
    assign mtvec_base = {trap.mtvec[`XLEN-1:2], 2'b00};
    // Interrupt bit drops out of the offset
    assign int_vector = (trap.mtvec[1:0] == 2'b01) ?
                        mtvec_base + {cause[`XLEN-3:0], 2'b00} : mtvec_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_csr_cmd <= CSR_X;
            trap_vector <= '0;
            mode_q      <= MODE_M;
        end else if (take_int) begin
            // Pipeline sees the interrupt as an ecall
            out_csr_cmd <= CSR_ECALL;
            trap_vector <= int_vector;
            mode_q      <= MODE_M;
        end else begin
            out_csr_cmd <= req.cmd;
            // Exceptions always go to the base
            if (trap.do_ecall) begin
                trap_vector <= mtvec_base;
                mode_q      <= MODE_M;
            end else if (trap.do_mret) begin
                trap_vector <= trap.mepc;
                mode_q      <= trap.mstatus.fields.mpp;
            end
        end
    end

    // mret restores MPP, which the register file keeps legal
    a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mode_q inside {MODE_U, MODE_M})
        else $error("illegal privilege mode %0d", mode_q);

endmodule

/* tb/csr_stage_tb.sv */
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_stage_tb;
    import csr_pkg::*;

    // mstatus and mie bit positions
    localparam logic [`XLEN-1:0] MST_MIE   = 32'h0000_0008;
    localparam logic [`XLEN-1:0] MST_MPIE  = 32'h0000_0080;
    localparam logic [`XLEN-1:0] MST_MPP_M = 32'h0000_1800;
    localparam logic [`XLEN-1:0] MIE_MTIE  = 32'h0000_0080;
    localparam int               WAIT_LIMIT = 50;

    // MXL = 1 in bits 31:30, extension letters A, I and M
    localparam logic [`XLEN-1:0] MISA_EXPECT = 32'h4000_0000 | (32'd1 << 0) |
                                               (32'd1 << 8) | (32'd1 << 12);
    // Environment call codes by mode
    localparam logic [`XLEN-1:0] ECALL_U_CODE = 32'd8;
    localparam logic [`XLEN-1:0] ECALL_M_CODE = 32'd11;
    // Interrupt flag in bit 31, machine timer is 7
    localparam logic [`XLEN-1:0] TIMER_INT_CODE = 32'h8000_0000 | 32'd7;

    logic                   clk;
    logic                   rst_n;
    logic [`COUNTER_W-1:0]  cycle;
    logic [`COUNTER_W-1:0]  time_cnt;
    logic [`COUNTER_W-1:0]  mtime;
    logic [`COUNTER_W-1:0]  mtimecmp;
    logic                   flush;
    csr_cmd_e               csr_cmd_in;
    logic [`XLEN-1:0]       op1_data;
    logic [`XLEN-1:0]       imm_i;
    logic                   interrupt_ready;
    logic [`XLEN-1:0]       fetch_pc;
    csr_cmd_e               out_csr_cmd;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       trap_vector;
    logic                   stall_may_interrupt;

    logic [15:0]            lfsr_state;
    logic [`XLEN-1:0]       scratch_val;
    string                  test_name;

    csr_stage csr_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // One LFSR step per bit
    task automatic random_word(output logic [`COUNTER_W-1:0] value);
        for (int i = 0; i < `COUNTER_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    task automatic load_counters();
        random_word(cycle);
        random_word(time_cnt);
    endtask

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string label, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error %s, %s: expected 0x%08h, actual 0x%08h",
                     test_name, label, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_cmd(input string label, input csr_cmd_e expected,
                             input csr_cmd_e actual);
        if (actual !== expected) begin
            $display("** Error %s, %s: expected %s, actual %s (%0d)",
                     test_name, label, expected.name(), actual.name(), actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string label, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s, %s: expected %b, actual %b",
                     test_name, label, expected, actual);
            stop_run();
        end
    endtask

    // One-cycle strobe, returns on the falling edge after the sampling edge
    task automatic issue_cmd(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`XLEN-1:0] op1, input logic kill);
        @(negedge clk);
        csr_cmd_in = cmd;
        imm_i      = {{(`XLEN-`CSR_ADDR_W){1'b0}}, addr};
        op1_data   = op1;
        flush      = kill;
        @(negedge clk);
        csr_cmd_in = CSR_X;
        imm_i      = '0;
        op1_data   = '0;
        flush      = 1'b0;
    endtask

    // csrrs with a zero operand
    task automatic expect_csr(input string label, input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [`XLEN-1:0] expected);
        issue_cmd(CSR_S, addr, '0, 1'b0);
        check_word(label, expected, csr_rdata);
    endtask

    // Old value comes back, new value follows the command rule
    task automatic apply_rmw(input string label, input logic [`CSR_ADDR_W-1:0] addr,
                             input csr_cmd_e cmd, input logic [`XLEN-1:0] operand,
                             input logic [`XLEN-1:0] old_val,
                             output logic [`XLEN-1:0] new_val);
        issue_cmd(cmd, addr, operand, 1'b0);
        check_word(label, old_val, csr_rdata);
        case (cmd)
            CSR_W:   new_val = operand;
            CSR_S:   new_val = old_val | operand;
            CSR_C:   new_val = old_val & ~operand;
            default: new_val = old_val;
        endcase
    endtask

    task automatic wait_for_stall(input logic expected);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (stall_may_interrupt !== expected && n < WAIT_LIMIT);
        if (stall_may_interrupt !== expected) begin
            $display("Timeout in %s: stall_may_interrupt did not become %b within %0d cycles",
                     test_name, expected, WAIT_LIMIT);
            stop_run();
        end
    endtask

    task automatic reset_identity();
        test_name = "reset_identity";
        check_cmd("out_csr_cmd", CSR_X, out_csr_cmd);
        check_word("csr_rdata", '0, csr_rdata);
        check_word("trap_vector", '0, trap_vector);
        check_flag("stall_may_interrupt", 1'b0, stall_may_interrupt);
        expect_csr("misa", `CSR_ADDR_MISA, MISA_EXPECT);
        expect_csr("mvendorid", `CSR_ADDR_MVENDORID, '0);
        expect_csr("mhartid", `CSR_ADDR_MHARTID, '0);
        expect_csr("mstatus", `CSR_ADDR_MSTATUS, MST_MPP_M);
    endtask

    task automatic write_set_clear();
        logic [`XLEN-1:0] v1;
        logic [`XLEN-1:0] v2;
        logic [`XLEN-1:0] v3;
        test_name = "write_set_clear";
        apply_rmw("mscratch write", `CSR_ADDR_MSCRATCH, CSR_W, 32'ha5a5_0f0f, '0, v1);
        apply_rmw("mscratch set", `CSR_ADDR_MSCRATCH, CSR_S, 32'h0000_f0f0, v1, v2);
        apply_rmw("mscratch clear", `CSR_ADDR_MSCRATCH, CSR_C, 32'ha000_0001, v2, v3);
        expect_csr("mscratch result", `CSR_ADDR_MSCRATCH, v3);
        scratch_val = v3;
        apply_rmw("mtvec write", `CSR_ADDR_MTVEC, CSR_W, 32'h8000_0100, '0, v1);
        apply_rmw("mtvec set", `CSR_ADDR_MTVEC, CSR_S, 32'h0000_0001, v1, v2);
        apply_rmw("mtvec clear", `CSR_ADDR_MTVEC, CSR_C, 32'h8000_0000, v2, v3);
        expect_csr("mtvec result", `CSR_ADDR_MTVEC, v3);
        // Low two bits of mepc are hardwired
        issue_cmd(CSR_W, `CSR_ADDR_MEPC, 32'h0000_1237, 1'b0);
        expect_csr("mepc aligned", `CSR_ADDR_MEPC, 32'h0000_1234);
        // Counter views are read only
        issue_cmd(CSR_W, `CSR_ADDR_CYCLE, 32'hffff_ffff, 1'b0);
        expect_csr("cycle after write", `CSR_ADDR_CYCLE, cycle[31:0]);
        issue_cmd(CSR_W, `CSR_ADDR_MCYCLEH, 32'h0000_0000, 1'b0);
        expect_csr("mcycleh after write", `CSR_ADDR_MCYCLEH, cycle[63:32]);
    endtask

    task automatic flush_counters();
        test_name = "flush_counters";
        issue_cmd(CSR_W, `CSR_ADDR_MSCRATCH, 32'h1357_9bdf, 1'b1);
        check_word("csr_rdata under flush", '0, csr_rdata);
        check_cmd("out_csr_cmd under flush", CSR_X, out_csr_cmd);
        expect_csr("mscratch after flush", `CSR_ADDR_MSCRATCH, scratch_val);
        load_counters();
        expect_csr("cycle", `CSR_ADDR_CYCLE, cycle[31:0]);
        expect_csr("cycleh", `CSR_ADDR_CYCLEH, cycle[63:32]);
        expect_csr("time", `CSR_ADDR_TIME, time_cnt[31:0]);
        expect_csr("timeh", `CSR_ADDR_TIMEH, time_cnt[63:32]);
        expect_csr("mcycle", `CSR_ADDR_MCYCLE, cycle[31:0]);
    endtask

    task automatic ecall_mret();
        test_name = "ecall_mret";
        // Direct mode vector
        issue_cmd(CSR_W, `CSR_ADDR_MTVEC, 32'h0000_1000, 1'b0);
        fetch_pc = 32'h0000_0200;
        issue_cmd(CSR_ECALL, '0, '0, 1'b0);
        check_cmd("ecall from M command", CSR_ECALL, out_csr_cmd);
        check_word("ecall from M vector", 32'h0000_1000, trap_vector);
        expect_csr("mcause after M ecall", `CSR_ADDR_MCAUSE, ECALL_M_CODE);
        expect_csr("mepc after M ecall", `CSR_ADDR_MEPC, 32'h0000_0200);
        expect_csr("mstatus after M ecall", `CSR_ADDR_MSTATUS, MST_MPP_M);
        // MPP to U with MPIE set, so mret lands in U with MIE on
        issue_cmd(CSR_W, `CSR_ADDR_MSTATUS, MST_MPIE, 1'b0);
        issue_cmd(CSR_W, `CSR_ADDR_MEPC, 32'h0000_0400, 1'b0);
        issue_cmd(CSR_MRET, '0, '0, 1'b0);
        check_cmd("mret command", CSR_MRET, out_csr_cmd);
        check_word("mret target", 32'h0000_0400, trap_vector);
        // U mode, machine registers hidden
        expect_csr("mstatus from U", `CSR_ADDR_MSTATUS, '0);
        issue_cmd(CSR_W, `CSR_ADDR_MSCRATCH, 32'hdead_beef, 1'b0);
        check_word("mscratch write from U", '0, csr_rdata);
        expect_csr("cycle from U", `CSR_ADDR_CYCLE, cycle[31:0]);
        fetch_pc = 32'h0000_0300;
        issue_cmd(CSR_ECALL, '0, '0, 1'b0);
        check_cmd("ecall from U command", CSR_ECALL, out_csr_cmd);
        check_word("ecall from U vector", 32'h0000_1000, trap_vector);
        // Back in M, previous mode U in MPP
        expect_csr("mstatus after U ecall", `CSR_ADDR_MSTATUS, MST_MPIE);
        expect_csr("mcause after U ecall", `CSR_ADDR_MCAUSE, ECALL_U_CODE);
        expect_csr("mepc after U ecall", `CSR_ADDR_MEPC, 32'h0000_0300);
        expect_csr("mscratch kept", `CSR_ADDR_MSCRATCH, scratch_val);
    endtask

    task automatic timer_interrupt();
        test_name = "timer_interrupt";
        // Vectored, base 0x2000
        issue_cmd(CSR_W, `CSR_ADDR_MTVEC, 32'h0000_2001, 1'b0);
        issue_cmd(CSR_W, `CSR_ADDR_MIE, MIE_MTIE, 1'b0);
        issue_cmd(CSR_S, `CSR_ADDR_MSTATUS, MST_MIE, 1'b0);
        @(negedge clk);
        check_flag("stall before compare match", 1'b0, stall_may_interrupt);
        mtimecmp = mtime;
        wait_for_stall(1'b1);
        expect_csr("mip timer pending", `CSR_ADDR_MIP, 32'h0000_0080);
        fetch_pc        = 32'h0000_0500;
        interrupt_ready = 1'b1;
        @(negedge clk);
        interrupt_ready = 1'b0;
        check_cmd("interrupt command", CSR_ECALL, out_csr_cmd);
        // Timer cause 7, four bytes per vector entry
        check_word("interrupt vector", 32'h0000_2000 + 32'd7 * 32'd4, trap_vector);
        wait_for_stall(1'b0);
        expect_csr("mcause after interrupt", `CSR_ADDR_MCAUSE, TIMER_INT_CODE);
        expect_csr("mepc after interrupt", `CSR_ADDR_MEPC, 32'h0000_0500);
        expect_csr("mstatus after interrupt", `CSR_ADDR_MSTATUS, MST_MPIE | MST_MPP_M);
        check_flag("stall with MIE clear", 1'b0, stall_may_interrupt);
    endtask

    initial begin
        lfsr_state      = 16'd45367;
        scratch_val     = '0;
        test_name       = "reset";
        rst_n           = 1'b0;
        flush           = 1'b0;
        csr_cmd_in      = CSR_X;
        op1_data        = '0;
        imm_i           = '0;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        // Compare far in the future, no timer match
        mtime           = 64'h0000_0000_0000_0100;
        mtimecmp        = '1;
        load_counters();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_identity();
        write_set_clear();
        flush_counters();
        ecall_mret();
        timer_interrupt();

        $display("No errors");
        $finish;
    end

endmodule
